/* source/common.sv */
package common;

    // basic machine types
    typedef logic [31:0] word_t;      // pc, instruction and data word
    typedef logic [4:0]  reg_idx_t;   // x0..x31

    // bubble markers
    localparam word_t NOP_PC = 32'hffff_ffff;  // pc of a bubble, never word aligned
    localparam word_t NOP_IR = 32'h0000_0013;  // addi x0, x0, 0

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // register-register alu
        OPC_OP_IMM = 7'b0010011,  // addi only
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011   // beq, bne
    } opcode_t;

    // funct3 / funct7 codes we decode
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,     // signed less-than, 0 or 1
        ALU_PASS_B   // lui passes the immediate
    } alu_op_t;

    // control transfer kind resolved in execute
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_ALWAYS    // jal
    } br_op_t;

    // decode -> execute payload
    typedef struct packed {
        logic     valid;    // low for a bubble
        word_t    pc;
        reg_idx_t rd;       // 0 when nothing is written
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        logic     use_imm;  // alu operand b from imm instead of rs2
        alu_op_t  alu_op;
        br_op_t   br_op;
    } id_ex_t;

    // execute -> writeback payload
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    result;
    } ex_wb_t;

endpackage

/* source/cpu_if.sv */
`timescale 1ns/1ps

module cpu_if #(
    parameter common::word_t RESET_PC = 32'h0  // first fetch address
) (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          halt_i,       // freeze pc, feed bubbles downstream

    output wire common::word_t imem_addr_o,  // rom address, data back next cycle
    input  wire common::word_t imem_data_i,

    input  wire common::word_t jmp_addr_i,   // from execute, combinational
    input  wire logic          jmp_valid_i,
    input  wire logic          ready_i,      // decode can take a new word

    output wire common::word_t pc_o,
    output wire common::word_t ir_o
);

import common::*;

word_t fetch_pc_r;   // pc whose word is on imem_data_i this cycle
word_t next_pc_w;
word_t pc_r;
word_t ir_r;

// next pc choice
always_comb begin
    next_pc_w = fetch_pc_r + 32'd4;            // sequential by default
    if (reset_i)
        next_pc_w = RESET_PC;
    else if (jmp_valid_i)
        next_pc_w = jmp_addr_i;                // a taken transfer is never dropped by halt
    else if (halt_i || !ready_i)
        next_pc_w = fetch_pc_r;                // hold, rom returns the same word again
end

assign imem_addr_o = next_pc_w;  // request the word for the next pc

always_ff @(posedge clk_i) begin
    fetch_pc_r <= next_pc_w;     // lines up with rom latency
end

// output register toward decode
always_ff @(posedge clk_i) begin
    if (reset_i || jmp_valid_i) begin
        pc_r <= NOP_PC;          // flush younger word
        ir_r <= NOP_IR;
    end else if (ready_i) begin
        if (halt_i) begin
            // fetched word waits at fetch_pc_r until halt drops
            pc_r <= NOP_PC;
            ir_r <= NOP_IR;
        end else begin
            pc_r <= fetch_pc_r;
            ir_r <= imem_data_i;
        end
    end
end

assign pc_o = pc_r;
assign ir_o = ir_r;

endmodule

/* source/cpu_id.sv */
`timescale 1ns/1ps

module cpu_id (
    input  wire logic             clk_i,
    input  wire logic             reset_i,

    input  wire common::word_t    pc_i,         // NOP_PC marks a bubble
    input  wire common::word_t    ir_i,
    input  wire logic             jmp_valid_i,  // flush from execute

    output wire logic             ready_o,      // low while stalled
    output wire common::reg_idx_t rs1_idx_o,    // register file read ports
    output wire common::reg_idx_t rs2_idx_o,
    input  wire common::word_t    rs1_val_i,
    input  wire common::word_t    rs2_val_i,

    output wire common::id_ex_t   id_ex_o
);

import common::*;

opcode_t    opcode;
logic [2:0] funct3;
logic [6:0] funct7;
reg_idx_t   rd, rs1, rs2;
word_t      imm_i, imm_u, imm_b, imm_j;
logic       legal;
logic       use_rs1, use_rs2;
logic       hazard, stall;
id_ex_t     id_ex_w;
id_ex_t     id_ex_r;

// instruction fields
assign opcode = opcode_t'(ir_i[6:0]);
assign funct3 = ir_i[14:12];
assign funct7 = ir_i[31:25];
assign rd     = ir_i[11:7];
assign rs1    = ir_i[19:15];
assign rs2    = ir_i[24:20];

// immediates, all sign extended from bit 31
assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
assign imm_u = {ir_i[31:12], 12'b0};
assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

assign rs1_idx_o = rs1;
assign rs2_idx_o = rs2;

always_comb begin
    legal           = 1'b0;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    id_ex_w.pc      = pc_i;
    id_ex_w.rd      = rd;
    id_ex_w.rs1_val = rs1_val_i;
    id_ex_w.rs2_val = rs2_val_i;
    id_ex_w.imm     = imm_i;
    id_ex_w.use_imm = 1'b0;
    id_ex_w.alu_op  = ALU_ADD;
    id_ex_w.br_op   = BR_NONE;
    case (opcode)
        OPC_OP: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            legal   = (funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
            case (funct3)
                F3_ADD_SUB: id_ex_w.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                F3_SLT:     id_ex_w.alu_op = ALU_SLT;
                F3_XOR:     id_ex_w.alu_op = ALU_XOR;
                F3_OR:      id_ex_w.alu_op = ALU_OR;
                F3_AND:     id_ex_w.alu_op = ALU_AND;
                default:    legal = 1'b0;  // sll, sltu, srl, sra not supported
            endcase
        end
        OPC_OP_IMM: begin
            legal           = (funct3 == F3_ADD_SUB);  // addi only
            use_rs1         = 1'b1;
            id_ex_w.use_imm = 1'b1;
        end
        OPC_LUI: begin
            legal           = 1'b1;
            id_ex_w.use_imm = 1'b1;
            id_ex_w.imm     = imm_u;
            id_ex_w.alu_op  = ALU_PASS_B;
        end
        OPC_JAL: begin
            legal         = 1'b1;
            id_ex_w.imm   = imm_j;
            id_ex_w.br_op = BR_ALWAYS;  // link value made in execute
        end
        OPC_BRANCH: begin
            use_rs1        = 1'b1;
            use_rs2        = 1'b1;
            id_ex_w.rd     = '0;        // no register write
            id_ex_w.imm    = imm_b;
            id_ex_w.alu_op = ALU_SUB;   // retire data is rs1 - rs2
            legal          = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            id_ex_w.br_op  = (funct3 == F3_BNE) ? BR_NE : BR_EQ;
        end
        default: ;  // anything else is a bubble
    endcase
    id_ex_w.valid = legal && (pc_i != NOP_PC);
    if (!id_ex_w.valid) begin
        id_ex_w.pc    = NOP_PC;
        id_ex_w.br_op = BR_NONE;
    end
end

// producer still in execute, its result is not in the register file yet
assign hazard = id_ex_w.valid && id_ex_r.valid && (id_ex_r.rd != '0) &&
                ((use_rs1 && rs1 == id_ex_r.rd) || (use_rs2 && rs2 == id_ex_r.rd));
assign stall   = hazard && !jmp_valid_i;  // flush wins, word is discarded anyway
assign ready_o = !stall;

always_ff @(posedge clk_i) begin
    if (reset_i || jmp_valid_i || stall) begin
        id_ex_r.valid <= 1'b0;     // bubble
        id_ex_r.pc    <= NOP_PC;
        id_ex_r.br_op <= BR_NONE;
    end else begin
        id_ex_r <= id_ex_w;
    end
end

assign id_ex_o = id_ex_r;

endmodule

/* source/cpu_ex.sv */
`timescale 1ns/1ps

module cpu_ex (
    input  wire logic           clk_i,
    input  wire logic           reset_i,

    input  wire common::id_ex_t id_ex_i,

    output wire common::word_t  jmp_addr_o,   // combinational from id_ex_i
    output wire logic           jmp_valid_o,  // one strobe per taken transfer

    output wire common::ex_wb_t ex_wb_o
);

import common::*;

word_t  op_a;
word_t  op_b;
word_t  alu_res;
word_t  result;
logic   taken;
ex_wb_t ex_wb_w;
ex_wb_t ex_wb_r;

assign op_a = id_ex_i.rs1_val;
assign op_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.rs2_val;  // operand b select

// alu
always_comb begin
    case (id_ex_i.alu_op)
        ALU_ADD:    alu_res = op_a + op_b;
        ALU_SUB:    alu_res = op_a - op_b;
        ALU_AND:    alu_res = op_a & op_b;
        ALU_OR:     alu_res = op_a | op_b;
        ALU_XOR:    alu_res = op_a ^ op_b;
        ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
        ALU_PASS_B: alu_res = op_b;
        default:    alu_res = op_a + op_b;
    endcase
end

// branch resolution, compares the raw register values
always_comb begin
    case (id_ex_i.br_op)
        BR_EQ:     taken = (id_ex_i.rs1_val == id_ex_i.rs2_val);
        BR_NE:     taken = (id_ex_i.rs1_val != id_ex_i.rs2_val);
        BR_ALWAYS: taken = 1'b1;
        default:   taken = 1'b0;
    endcase
end

assign jmp_valid_o = id_ex_i.valid && taken;
assign jmp_addr_o  = id_ex_i.pc + id_ex_i.imm;  // same target form for jal and branches

// jal links pc + 4
assign result = (id_ex_i.br_op == BR_ALWAYS) ? id_ex_i.pc + 32'd4 : alu_res;

always_comb begin
    ex_wb_w.valid  = id_ex_i.valid;
    ex_wb_w.pc     = id_ex_i.pc;     // already NOP_PC for a bubble
    ex_wb_w.rd     = id_ex_i.rd;
    ex_wb_w.result = result;
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        ex_wb_r.valid <= 1'b0;
        ex_wb_r.pc    <= NOP_PC;
    end else begin
        ex_wb_r <= ex_wb_w;
    end
end

assign ex_wb_o = ex_wb_r;

endmodule

/* source/cpu_wb.sv */
`timescale 1ns/1ps

module cpu_wb (
    input  wire logic             clk_i,
    input  wire logic             reset_i,

    input  wire common::ex_wb_t   ex_wb_i,

    input  wire common::reg_idx_t rs1_idx_i,      // read ports for decode
    input  wire common::reg_idx_t rs2_idx_i,
    output wire common::word_t    rs1_val_o,
    output wire common::word_t    rs2_val_o,

    output wire logic             retire_valid_o,  // one pulse per instruction
    output wire common::word_t    retire_pc_o,
    output wire common::reg_idx_t retire_rd_o,
    output wire common::word_t    retire_data_o
);

import common::*;

word_t    regs [1:31];  // x0 not stored
logic     wr_en;
word_t    rs1_val, rs2_val;
logic     retire_valid_r;
word_t    retire_pc_r;
reg_idx_t retire_rd_r;
word_t    retire_data_r;

assign wr_en = ex_wb_i.valid && (ex_wb_i.rd != '0);

always_ff @(posedge clk_i) begin
    if (wr_en)
        regs[ex_wb_i.rd] <= ex_wb_i.result;
end

// read with write-through, x0 reads zero
function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0)
        return '0;
    else if (wr_en && idx == ex_wb_i.rd)
        return ex_wb_i.result;  // value written this cycle
    else
        return regs[idx];
endfunction

always_comb begin
    rs1_val = read_port(rs1_idx_i);
    rs2_val = read_port(rs2_idx_i);
end

assign rs1_val_o = rs1_val;
assign rs2_val_o = rs2_val;

// retire report, one edge after writeback
always_ff @(posedge clk_i) begin
    retire_valid_r <= reset_i ? 1'b0 : ex_wb_i.valid;
    retire_pc_r    <= ex_wb_i.pc;
    retire_rd_r    <= ex_wb_i.rd;
    retire_data_r  <= ex_wb_i.result;
end

assign retire_valid_o = retire_valid_r;
assign retire_pc_o    = retire_pc_r;
assign retire_rd_o    = retire_rd_r;
assign retire_data_o  = retire_data_r;

endmodule

/* source/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter common::word_t RESET_PC = 32'h0  // passed down to fetch
) (
    input  wire logic             clk_i,
    input  wire logic             reset_i,
    input  wire logic             halt_i,

    output wire common::word_t    imem_addr_o,  // synchronous rom outside the core
    input  wire common::word_t    imem_data_i,

    output wire logic             retire_valid_o,
    output wire common::word_t    retire_pc_o,
    output wire common::reg_idx_t retire_rd_o,
    output wire common::word_t    retire_data_o
);

import common::*;

word_t    if_pc, if_ir;          // fetch -> decode
logic     id_ready;              // decode -> fetch
reg_idx_t rs1_idx, rs2_idx;      // decode <-> register file
word_t    rs1_val, rs2_val;
id_ex_t   id_ex;
word_t    jmp_addr;              // execute -> fetch
logic     jmp_valid;             // execute -> fetch, decode
ex_wb_t   ex_wb;

cpu_if #(
    .RESET_PC    (RESET_PC)
) if0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .halt_i      (halt_i),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .jmp_addr_i  (jmp_addr),
    .jmp_valid_i (jmp_valid),
    .ready_i     (id_ready),
    .pc_o        (if_pc),
    .ir_o        (if_ir)
);

cpu_id id0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pc_i        (if_pc),
    .ir_i        (if_ir),
    .jmp_valid_i (jmp_valid),
    .ready_o     (id_ready),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rs1_val_i   (rs1_val),
    .rs2_val_i   (rs2_val),
    .id_ex_o     (id_ex)
);

cpu_ex ex0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .id_ex_i     (id_ex),
    .jmp_addr_o  (jmp_addr),
    .jmp_valid_o (jmp_valid),
    .ex_wb_o     (ex_wb)
);

cpu_wb wb0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ex_wb_i        (ex_wb),
    .rs1_idx_i      (rs1_idx),
    .rs2_idx_i      (rs2_idx),
    .rs1_val_o      (rs1_val),
    .rs2_val_o      (rs2_val),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
);

endmodule

/* test/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare tasks, stop at the first mismatch
task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
        abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
endtask

task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp)
        abort_run($sformatf("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp));
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
        abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
endtask

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic word_t lfsr_bits(int n);
    word_t val;
    logic  fb;
    int    i;
    val = '0;
    for (i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        val    = {val[30:0], fb};
    end
    return val;
endfunction

// small assembler, rv32i field layouts
function automatic word_t rtype_word(logic [6:0] f7, logic [2:0] f3,
                                     reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t addi_word(reg_idx_t rd, reg_idx_t rs1, int imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic word_t lui_word(reg_idx_t rd, int imm);
    return {imm[19:0], rd, 7'b0110111};  // imm is the upper 20 bits
endfunction

function automatic word_t jal_word(reg_idx_t rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// f3 0 for beq, 1 for bne
function automatic word_t branch_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, int off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

`endif

/* test/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;

import common::*;

localparam word_t RESET_PC       = 32'h0000_0200;  // fetch starts here after reset
localparam int    RETIRE_TIMEOUT = 200;            // cycles per retire wait

logic     clk_i = 1'b0;
logic     reset_i;
logic     halt_i;
word_t    imem_addr_o;
word_t    imem_data_i = NOP_IR;
logic     retire_valid_o;
word_t    retire_pc_o;
reg_idx_t retire_rd_o;
word_t    retire_data_o;

word_t    prog[$];       // program image starting at RESET_PC
word_t    exp_pc[$];     // expected retire sequence from the reference model
reg_idx_t exp_rd[$];
word_t    exp_data[$];
word_t    lfsr_q = 32'h733;
int       cycle_cnt;     // edges since reset release
int       halt_from;
int       halt_len;      // 0 means no halt window

task automatic abort_run(string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at first error");
endtask

`include "tb_checks.svh"

always #5 clk_i = ~clk_i;  // 10 ns period

cpu_core #(
    .RESET_PC       (RESET_PC)
) dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .halt_i         (halt_i),
    .imem_addr_o    (imem_addr_o),
    .imem_data_i    (imem_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
);

// synchronous rom, outside the program it returns addi x0, x0, 0
function automatic word_t rom_word(word_t addr);
    word_t offs;
    offs = addr - RESET_PC;  // wraps high below RESET_PC
    if (addr[1:0] != 2'b00 || offs >= word_t'(4 * prog.size()))
        return NOP_IR;
    return prog[offs >> 2];
endfunction

always @(posedge clk_i)
    imem_data_i <= rom_word(imem_addr_o);

// reference interpreter, fills the expected retire queues
task automatic run_reference();
    word_t    regs [32];
    word_t    pc, ir, a, b, res, nxt;
    reg_idx_t rd;
    int       steps;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (regs[i])
        regs[i] = '0;
    pc    = RESET_PC;
    steps = 0;
    while ((pc - RESET_PC) < word_t'(4 * prog.size()) && steps < 400) begin
        ir  = prog[(pc - RESET_PC) >> 2];
        rd  = ir[11:7];
        a   = regs[ir[19:15]];
        b   = regs[ir[24:20]];
        nxt = pc + 32'd4;
        res = '0;
        case (ir[6:0])
            7'h13: res = a + {{20{ir[31]}}, ir[31:20]};  // addi
            7'h37: res = {ir[31:12], 12'h000};            // lui
            7'h6f: begin                                  // jal
                res = pc + 32'd4;
                nxt = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            7'h63: begin                                  // beq / bne, no write
                res = a - b;
                rd  = '0;
                if (ir[12] ? (a != b) : (a == b))
                    nxt = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            7'h33: case ({ir[30], ir[14:12]})
                4'b0000: res = a + b;
                4'b1000: res = a - b;
                4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4'b0100: res = a ^ b;
                4'b0110: res = a | b;
                default: res = a & b;  // 111 is the only other one generated
            endcase
            default: abort_run("reference model met an unsupported instruction");
        endcase
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        if (rd != '0)
            regs[rd] = res;
        pc = nxt;
        steps++;
    end
endtask

// 4 cycles of reset, retire must stay quiet
task automatic apply_reset();
    int i;
    @(posedge clk_i);
    reset_i <= 1'b1;
    halt_i  <= 1'b0;
    for (i = 0; i < 4; i++) begin
        @(posedge clk_i);
        if (i == 3)
            reset_i <= 1'b0;  // next edge is the first one out of reset
        @(negedge clk_i);
        check_flag("retire_valid_o", retire_valid_o, 1'b0);
        // reset vector while in reset, the word after it once reset drops
        check_word("imem_addr_o", imem_addr_o, (i == 3) ? RESET_PC + 32'd4 : RESET_PC);
    end
    cycle_cnt = 0;
endtask

// one clock, halt driven on the rising edge, outputs sampled on the falling edge
task automatic step_cycle();
    @(posedge clk_i);
    halt_i <= (halt_len > 0) && (cycle_cnt >= halt_from) && (cycle_cnt < halt_from + halt_len);
    cycle_cnt++;
    @(negedge clk_i);
endtask

// fetch halted long enough that everything older has left the pipeline
function automatic bit halt_drained();
    return (cycle_cnt >= halt_from + 6) && (cycle_cnt <= halt_from + halt_len + 4);
endfunction

task automatic wait_retire();
    int n;
    for (n = 0; n < RETIRE_TIMEOUT; n++) begin
        step_cycle();
        if (retire_valid_o === 1'b1) begin
            if (halt_drained())
                abort_run("an instruction retired after the halted pipeline had drained");
            return;
        end
    end
    abort_run("timeout: no instruction retired within 200 cycles");
endtask

function automatic void emit(word_t w);
    prog.push_back(w);
endfunction

// x1..x8 get random values, no dependencies between them
task automatic emit_prologue();
    int i;
    for (i = 1; i <= 8; i++)
        emit(addi_word(reg_idx_t'(i), 0, int'(lfsr_bits(12))));
endtask

// random alu ops, sources from x1..x8
task automatic emit_random_block(int count, int rd_base, int rd_bits);
    int       i;
    reg_idx_t rd, rs1, rs2;
    for (i = 0; i < count; i++) begin
        rd  = reg_idx_t'(rd_base + int'(lfsr_bits(rd_bits)));
        rs1 = reg_idx_t'(1 + int'(lfsr_bits(3)));
        rs2 = reg_idx_t'(1 + int'(lfsr_bits(3)));
        case (lfsr_bits(3))
            0: emit(addi_word(rd, rs1, int'(lfsr_bits(12))));
            1: emit(rtype_word(7'h00, 3'h0, rd, rs1, rs2));  // add
            2: emit(rtype_word(7'h20, 3'h0, rd, rs1, rs2));  // sub
            3: emit(rtype_word(7'h00, 3'h7, rd, rs1, rs2));  // and
            4: emit(rtype_word(7'h00, 3'h6, rd, rs1, rs2));  // or
            5: emit(rtype_word(7'h00, 3'h4, rd, rs1, rs2));  // xor
            6: emit(rtype_word(7'h00, 3'h2, rd, rs1, rs2));  // slt
            default: emit(lui_word(rd, int'(lfsr_bits(20))));
        endcase
    end
endtask

task automatic run_program();
    int i;
    run_reference();
    apply_reset();
    for (i = 0; i < exp_pc.size(); i++) begin
        wait_retire();
        check_word("retire_pc_o", retire_pc_o, exp_pc[i]);
        check_reg("retire_rd_o", retire_rd_o, exp_rd[i]);
        check_word("retire_data_o", retire_data_o, exp_data[i]);
    end
endtask

// first retire after reset comes from RESET_PC
task automatic test_reset_retire();
    prog.delete();
    emit(addi_word(1, 0, 17));
    emit(addi_word(2, 0, 34));
    apply_reset();
    wait_retire();
    check_word("retire_pc_o", retire_pc_o, RESET_PC);
    check_reg("retire_rd_o", retire_rd_o, 1);
    check_word("retire_data_o", retire_data_o, 32'd17);
endtask

task automatic test_arith();
    prog.delete();
    emit_prologue();
    emit_random_block(24, 9, 4);  // rd in x9..x24, never read back
    run_program();
endtask

// stall on the op right ahead, bypass on the one two ahead
task automatic test_dependent();
    prog.delete();
    emit(addi_word(1, 0, 5));
    emit(rtype_word(7'h00, 3'h0, 2, 1, 1));
    emit(rtype_word(7'h20, 3'h0, 3, 2, 1));
    emit(rtype_word(7'h00, 3'h4, 3, 3, 2));
    emit(addi_word(3, 3, -7));
    emit(rtype_word(7'h00, 3'h2, 4, 3, 2));
    emit(lui_word(5, int'(lfsr_bits(20))));
    emit(addi_word(5, 5, int'(lfsr_bits(12))));
    emit(rtype_word(7'h00, 3'h6, 6, 5, 3));
    emit(rtype_word(7'h00, 3'h7, 7, 6, 5));
    emit(rtype_word(7'h00, 3'h0, 8, 7, 7));
    emit(addi_word(9, 1, 1));                 // gap of one
    emit(rtype_word(7'h00, 3'h0, 10, 8, 9));  // x8 two ahead
    run_program();
endtask

// x10 is written only by instructions that must be flushed
task automatic test_branches();
    prog.delete();
    emit(addi_word(1, 0, 3));
    emit(addi_word(2, 0, 3));
    emit(addi_word(3, 0, 4));
    emit(branch_word(3'h0, 1, 2, 12));  // beq taken
    emit(addi_word(10, 0, 1));
    emit(addi_word(10, 0, 2));
    emit(branch_word(3'h0, 1, 3, 8));   // beq not taken
    emit(addi_word(11, 1, 5));
    emit(branch_word(3'h1, 1, 3, 12));  // bne taken
    emit(addi_word(10, 0, 3));
    emit(addi_word(10, 0, 4));
    emit(jal_word(5, 12));              // link in x5
    emit(addi_word(10, 0, 5));
    emit(addi_word(10, 0, 6));
    emit(addi_word(12, 5, 1));
    emit(branch_word(3'h1, 1, 2, 8));   // bne not taken
    emit(addi_word(13, 12, 7));
    emit(addi_word(20, 0, 3));          // backward loop, three passes
    emit(addi_word(20, 20, -1));
    emit(branch_word(3'h1, 20, 0, -4));
    emit(jal_word(0, 8));
    emit(addi_word(10, 0, 7));
    emit(addi_word(21, 20, 9));
    run_program();
endtask

task automatic test_halt();
    prog.delete();
    emit_prologue();
    emit_random_block(20, 1, 3);  // rd in x1..x8, plenty of hazards
    halt_from = 6 + int'(lfsr_bits(3));
    halt_len  = 2 + int'(lfsr_bits(4));
    run_program();
    halt_len = 0;
endtask

task automatic test_x0();
    prog.delete();
    emit(addi_word(0, 0, 55));
    emit(lui_word(0, int'(lfsr_bits(20))));
    emit(rtype_word(7'h00, 3'h0, 1, 0, 0));  // x0 + x0
    emit(addi_word(2, 0, 7));
    emit(rtype_word(7'h00, 3'h6, 3, 2, 0));
    emit(addi_word(0, 2, 1));                // x0 write just before a read
    emit(rtype_word(7'h20, 3'h0, 4, 0, 2));
    run_program();
endtask

initial begin
    reset_i   = 1'b1;
    halt_i    = 1'b0;
    halt_from = 0;
    halt_len  = 0;
    cycle_cnt = 0;
    test_reset_retire();
    test_arith();
    test_dependent();
    test_branches();
    test_halt();
    test_x0();
    $display("Finished with no errors");
    $finish;
end

endmodule

/* cpu_core.f */
+incdir+test
source/common.sv
source/cpu_if.sv
source/cpu_id.sv
source/cpu_ex.sv
source/cpu_wb.sv
source/cpu_core.sv
test/tb_cpu_core.sv

/* run.sh */
#!/usr/bin/env bash
# build the cpu_core testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_cpu_core -Mdir obj_dir -f cpu_core.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu_core 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
